// File: src.f
isaPkg.sv
ctrlPkg.sv
control.sv
immExtend.sv
regFile.sv
alu.sv
nextPc.sv
wiscCore.sv
wiscCoreTb.sv

// File: Makefile
.PHONY: run clean

run: obj_dir/VwiscCoreTb
	./obj_dir/VwiscCoreTb | tee sim.log
	grep -q "Finished with no errors" sim.log

obj_dir/VwiscCoreTb: src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module wiscCoreTb

clean:
	rm -rf obj_dir sim.log

// File: wiscCoreTb.sv
// WISC core testbench
`timescale 1ns/1ps
module wiscCoreTb;
    logic        clk = 1'b0;
    logic        rstN = 1'b0;
    logic [15:0] instr, pc, memAddr, memWData, memRData, regWData;
    logic        memEn, memWr, regWe, halted;
    logic [2:0]  regWAddr;
    logic [15:0] imem [0:127];                 // Program words indexed by pc / 2
    logic [15:0] dmem [0:255];                 // Word-addressed data memory
    logic [6:0]  progLen;                      // Next free program slot
    logic [15:0] sh [0:7];                     // Shadow register file
    logic [15:0] mPc, expPc, expWData, expMemAddr, rsV, rtV, i5s, i8s, i11s, pcInc;
    logic        mHalted, expHalt, expWe, expMemEn, expMemWr;
    logic [2:0]  expWAddr;

    wiscCore i_wiscCore (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .memEn(memEn), .memWr(memWr),
        .memAddr(memAddr), .memWData(memWData), .memRData(memRData), .regWe(regWe),
        .regWAddr(regWAddr), .regWData(regWData), .halted(halted)
    );

    always #5 clk = ~clk;                      // 10 ns period

    assign instr    = imem[pc[7:1]];           // Fetch answers in the same cycle
    assign memRData = dmem[memAddr[8:1]];

    function automatic logic [15:0] aluModel(input logic [4:0] op, input logic [1:0] fn,
                                             input logic [15:0] a, input logic [15:0] b);
        logic [4:0]  k;
        logic [16:0] s;
        logic [3:0]  n;
        k = op;
        if (op == isaPkg::opArith) k = {3'b010, fn};  // R groups reuse the immediate codes
        if (op == isaPkg::opShift) k = {3'b101, fn};
        s = {1'b0, a} + {1'b0, b};
        n = b[3:0];                            // Only the low 4 bits shift
        case (k)
            isaPkg::opSubi:  return b - a;     // Rt minus Rs
            isaPkg::opXori:  return a ^ b;
            isaPkg::opAndni: return a & ~b;
            isaPkg::opRoli:  return (a << n) | (a >> (5'd16 - {1'b0, n}));
            isaPkg::opSlli:  return a << n;
            isaPkg::opRori:  return (a >> n) | (a << (5'd16 - {1'b0, n}));
            isaPkg::opSrli:  return a >> n;
            isaPkg::opSeq:   return {15'd0, a == b};
            isaPkg::opSlt:   return {15'd0, $signed(a) < $signed(b)};
            isaPkg::opSle:   return {15'd0, $signed(a) <= $signed(b)};
            isaPkg::opSco:   return {15'd0, s[16]};
            isaPkg::opBtr:   return {<<{a}};   // Bit reverse
            default:         return s[15:0];
        endcase
    endfunction

    // Expected response of the current instruction
    always_comb begin
        rsV        = sh[instr[10:8]];
        rtV        = sh[instr[7:5]];
        i5s        = {{11{instr[4]}}, instr[4:0]};
        i8s        = {{8{instr[7]}}, instr[7:0]};
        i11s       = {{5{instr[10]}}, instr[10:0]};
        pcInc      = mPc + 16'd2;
        expWe      = 1'b0;
        expWAddr   = instr[10:8];              // Rs unless the format says otherwise
        expWData   = '0;
        expMemEn   = 1'b0;
        expMemWr   = 1'b0;
        expMemAddr = rsV + i5s;
        expPc      = pcInc;
        expHalt    = 1'b0;
        case (instr[15:11])
            isaPkg::opHalt: begin
                expHalt = 1'b1;
                expPc   = mPc;
            end
            isaPkg::opAddi, isaPkg::opSubi: begin
                expWe    = 1'b1;
                expWAddr = instr[7:5];
                expWData = aluModel(instr[15:11], 2'd0, rsV, i5s);
            end
            isaPkg::opXori, isaPkg::opAndni,
            isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
                expWe    = 1'b1;
                expWAddr = instr[7:5];
                expWData = aluModel(instr[15:11], 2'd0, rsV, {11'd0, instr[4:0]});
            end
            isaPkg::opArith, isaPkg::opShift, isaPkg::opBtr,
            isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco: begin
                expWe    = 1'b1;
                expWAddr = instr[4:2];
                expWData = aluModel(instr[15:11], instr[1:0], rsV, rtV);
            end
            isaPkg::opLbi: begin
                expWe    = 1'b1;
                expWData = i8s;
            end
            isaPkg::opSlbi: begin
                expWe    = 1'b1;
                expWData = {rsV[7:0], instr[7:0]};
            end
            isaPkg::opSt, isaPkg::opStu: begin
                expMemEn = 1'b1;
                expMemWr = 1'b1;
                expWe    = (instr[15:11] == isaPkg::opStu);  // STU updates Rs
                expWData = expMemAddr;
            end
            isaPkg::opLd: begin
                expMemEn = 1'b1;
                expWe    = 1'b1;
                expWAddr = instr[7:5];
                expWData = dmem[expMemAddr[8:1]];
            end
            isaPkg::opBeqz: if (rsV == 16'd0) expPc = pcInc + i8s;
            isaPkg::opBnez: if (rsV != 16'd0) expPc = pcInc + i8s;
            isaPkg::opBltz: if (rsV[15]) expPc = pcInc + i8s;
            isaPkg::opBgez: if (!rsV[15]) expPc = pcInc + i8s;
            isaPkg::opJ, isaPkg::opJal, isaPkg::opJr, isaPkg::opJalr: begin
                expPc    = instr[11] ? rsV + i8s : pcInc + i11s;  // Odd codes jump from Rs
                expWe    = instr[12];          // JAL and JALR link
                expWAddr = isaPkg::linkReg;
                expWData = pcInc;
            end
            default: ;                         // NOP, SIIC and RTI just advance
        endcase
        if (mHalted) begin
            expWe    = 1'b0;
            expMemEn = 1'b0;
            expMemWr = 1'b0;
            expPc    = mPc;
        end
    end

    always @(posedge clk) begin
        if (!rstN) begin
            mPc     <= '0;
            mHalted <= 1'b0;
            sh      <= '{default: '0};
            for (int i = 0; i < 256; i++) begin
                dmem[8'(i)] <= {8'(i), ~8'(i)};  // Distinct word per address
            end
        end else begin
            if (expWe) sh[expWAddr] <= expWData;
            if (expHalt) mHalted <= 1'b1;
            mPc <= expPc;
            if (memEn && memWr) dmem[memAddr[8:1]] <= memWData;
        end
    end

    task automatic failValue(input string name, input logic [15:0] expV, input logic [15:0] gotV);
        $display("Fail at %0t ns: %s expected %h got %h", $time, name, expV, gotV);
        $display("Finished with errors");
        $fatal(1, "Mismatch on %s", name);
    endtask

    pcCheck: assert property (@(posedge clk) rstN |-> pc == mPc)
        else failValue("pc", $sampled(mPc), $sampled(pc));
    haltedCheck: assert property (@(posedge clk) rstN |-> halted == mHalted)
        else failValue("halted", {15'd0, $sampled(mHalted)}, {15'd0, $sampled(halted)});
    weCheck: assert property (@(posedge clk) rstN |-> regWe == expWe)
        else failValue("regWe", {15'd0, $sampled(expWe)}, {15'd0, $sampled(regWe)});
    wAddrCheck: assert property (@(posedge clk) rstN && expWe |-> regWAddr == expWAddr)
        else failValue("regWAddr", {13'd0, $sampled(expWAddr)}, {13'd0, $sampled(regWAddr)});
    wDataCheck: assert property (@(posedge clk) rstN && expWe |-> regWData == expWData)
        else failValue("regWData", $sampled(expWData), $sampled(regWData));
    memEnCheck: assert property (@(posedge clk) rstN |-> memEn == expMemEn)
        else failValue("memEn", {15'd0, $sampled(expMemEn)}, {15'd0, $sampled(memEn)});
    memWrCheck: assert property (@(posedge clk) rstN |-> memWr == expMemWr)
        else failValue("memWr", {15'd0, $sampled(expMemWr)}, {15'd0, $sampled(memWr)});
    memAddrCheck: assert property (@(posedge clk) rstN && expMemEn |-> memAddr == expMemAddr)
        else failValue("memAddr", $sampled(expMemAddr), $sampled(memAddr));
    memWDataCheck: assert property (@(posedge clk) rstN && expMemWr |-> memWData == rtV)
        else failValue("memWData", $sampled(rtV), $sampled(memWData));

    function automatic logic [15:0] encodeR(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [2:0] rd,
                                            input logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI1(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [2:0] rd, input logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic logic [15:0] encodeI2(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic logic [15:0] encodeJ(input logic [4:0] op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic startProgram();
        imem    = '{default: '0};              // Unused words decode as HALT
        progLen = '0;
    endtask

    task automatic emit(input logic [15:0] word);
        imem[progLen] = word;
        progLen       = progLen + 7'd1;
    endtask

    task automatic loadReg(input logic [2:0] r, input logic [15:0] v);
        emit(encodeI2(isaPkg::opLbi, r, v[15:8]));   // Upper byte with sign extension
        emit(encodeI2(isaPkg::opSlbi, r, v[7:0]));   // Shift up and fill low byte
    endtask

    task automatic buildAluProgram();
        logic [4:0] op;
        startProgram();
        emit(encodeJ(isaPkg::opNop, 11'd0));
        emit(encodeJ(isaPkg::opSiic, 11'd0));
        emit(encodeJ(isaPkg::opRti, 11'd0));
        for (int r = 0; r < 8; r++) loadReg(3'(r), 16'($urandom));
        repeat (2) begin
            for (int k = 0; k < 12; k++) begin   // Every funct of both R groups and the compares
                op = (k < 4) ? isaPkg::opArith : (k < 8) ? isaPkg::opShift : {3'b111, 2'(k)};
                emit(encodeR(op, 3'($urandom), 3'($urandom), 3'($urandom), 2'(k)));
            end
        end
        emit(encodeR(isaPkg::opBtr, 3'($urandom), 3'd0, 3'($urandom), 2'd0));
        emit(encodeR(isaPkg::opSeq, 3'd2, 3'd2, 3'd5, 2'd0));  // Equal operands
        for (int k = 0; k < 8; k++) begin
            op = k[2] ? {3'b101, 2'(k)} : {3'b010, 2'(k)};
            emit(encodeI1(op, 3'($urandom), 3'($urandom), 5'($urandom)));
        end
        emit(encodeJ(isaPkg::opHalt, 11'd0));
    endtask

    task automatic buildMemProgram();
        logic [2:0] base;
        logic [2:0] data;
        logic [4:0] off;
        startProgram();
        for (int r = 0; r < 8; r++) loadReg(3'(r), 16'($urandom));
        repeat (6) begin
            base = 3'($urandom);
            data = 3'($urandom);
            off  = 5'($urandom);
            emit(encodeI1(isaPkg::opSt, base, data, off));
            emit(encodeI1(isaPkg::opLd, base, 3'($urandom), off));  // Reads the stored word
            emit(encodeI1(isaPkg::opStu, base, data, off));
            emit(encodeI1(isaPkg::opLd, 3'($urandom), 3'($urandom), 5'($urandom)));
        end
        emit(encodeJ(isaPkg::opHalt, 11'd0));
    endtask

    task automatic buildBranchProgram();
        startProgram();
        loadReg(3'd1, 16'd0);
        loadReg(3'd2, 16'h8000 | 16'($urandom));          // Negative
        loadReg(3'd3, (16'($urandom) & 16'h7fff) | 16'd1); // Positive
        for (int b = 0; b < 4; b++) begin
            for (int r = 1; r < 4; r++) begin
                emit(encodeI2({3'b011, 2'(b)}, 3'(r), 8'd2));  // Taken skips the ADDI
                emit(encodeI1(isaPkg::opAddi, 3'd4, 3'd4, 5'd1));
            end
        end
        emit(encodeJ(isaPkg::opJ, 11'd2));
        emit(encodeI1(isaPkg::opAddi, 3'd4, 3'd4, 5'd1));
        emit(encodeJ(isaPkg::opJal, 11'd2));
        emit(encodeI1(isaPkg::opAddi, 3'd4, 3'd4, 5'd1));
        loadReg(3'd5, {8'd0, progLen + 7'd3, 1'b0});       // Target lands past the filler
        emit(encodeI2(isaPkg::opJr, 3'd5, 8'd2));
        emit(encodeI1(isaPkg::opAddi, 3'd4, 3'd4, 5'd1));
        loadReg(3'd6, {8'd0, progLen + 7'd3, 1'b0});
        emit(encodeI2(isaPkg::opJalr, 3'd6, 8'd2));
        emit(encodeI1(isaPkg::opAddi, 3'd4, 3'd4, 5'd1));
        emit(encodeJ(isaPkg::opHalt, 11'd0));
    endtask

    task automatic runProgram();
        int cycles;
        @(posedge clk);
        rstN <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        cycles = 0;
        while (!halted && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", cycles);
            $display("Finished with errors");
            $fatal(1, "Halt timeout");
        end
        repeat (4) @(negedge clk);             // Core must stay parked
    endtask

    initial begin
        void'($urandom(39));
        buildAluProgram();
        runProgram();
        buildMemProgram();
        runProgram();
        buildBranchProgram();
        runProgram();
        $display("Finished with no errors");
        $finish;
    end
endmodule

// File: wiscCore.sv
// Single-cycle WISC core
`timescale 1ns/1ps
module wiscCore (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [isaPkg::dataW-1:0]    instr,
    output logic [isaPkg::dataW-1:0]    pc,
    output logic                        memEn,
    output logic                        memWr,
    output logic [isaPkg::dataW-1:0]    memAddr,
    output logic [isaPkg::dataW-1:0]    memWData,
    input  logic [isaPkg::dataW-1:0]    memRData,
    output logic                        regWe,
    output logic [isaPkg::regAddrW-1:0] regWAddr,
    output logic [isaPkg::dataW-1:0]    regWData,
    output logic                        halted
);
    logic                     regWrite, pcSel, regJmp, memEnable, ctrlMemWr;
    logic                     val2Reg, aluSel, halt, branch;
    logic [1:0]               destRegSel, linkSel;
    logic [2:0]               immSel;
    logic [isaPkg::opW-1:0]   aluCntrl;
    logic [isaPkg::dataW-1:0] imm, rsVal, rtVal, aluOpB, aluResult, pcPlus2;

    control i_control (
        .instrOp(instr[15:11]), .regWrite(regWrite), .destRegSel(destRegSel),
        .pcSel(pcSel), .regJmp(regJmp), .memEnable(memEnable), .memWr(ctrlMemWr),
        .aluCntrl(aluCntrl), .val2Reg(val2Reg), .aluSel(aluSel), .immSel(immSel),
        .halt(halt), .linkSel(linkSel), .branch(branch)
    );

    immExtend i_immExtend (.instr(instr), .immSel(immSel), .imm(imm));

    // Port B reads Rt, which is also the store data field
    regFile i_regFile (
        .clk(clk), .rstN(rstN), .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
        .rdDataA(rsVal), .rdDataB(rtVal), .we(regWe), .wrAddr(regWAddr), .wrData(regWData)
    );

    assign aluOpB = aluSel ? imm : rtVal;

    alu i_alu (
        .opA(rsVal), .opB(aluOpB), .aluCntrl(aluCntrl), .funct(instr[1:0]), .result(aluResult)
    );

    nextPc i_nextPc (
        .clk(clk), .rstN(rstN), .instr(instr), .rsVal(rsVal), .imm(imm), .pcSel(pcSel),
        .regJmp(regJmp), .branch(branch), .halt(halt), .pc(pc), .pcPlus2(pcPlus2),
        .halted(halted)
    );

    always_comb begin
        case (destRegSel)
            ctrlPkg::destSelRs:  regWAddr = instr[10:8];
            ctrlPkg::destSelRdR: regWAddr = instr[4:2];
            ctrlPkg::destSelR7:  regWAddr = isaPkg::linkReg;
            default:             regWAddr = instr[7:5];  // Rd of I-format 1
        endcase
        if (val2Reg) regWData = memRData;
        else if (linkSel == ctrlPkg::linkPc) regWData = pcPlus2;
        else if (linkSel == ctrlPkg::linkLbi) regWData = imm;
        else regWData = aluResult;
    end

    assign regWe    = regWrite & ~halted;      // Nothing retires once halted
    assign memEn    = memEnable & ~halted;
    assign memWr    = ctrlMemWr & ~halted;
    assign memAddr  = aluResult;
    assign memWData = rtVal;
endmodule

// File: nextPc.sv
// Program counter and halt state
`timescale 1ns/1ps
module nextPc (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [isaPkg::dataW-1:0] instr,
    input  logic [isaPkg::dataW-1:0] rsVal,
    input  logic [isaPkg::dataW-1:0] imm,
    input  logic                     pcSel,
    input  logic                     regJmp,
    input  logic                     branch,
    input  logic                     halt,
    output logic [isaPkg::dataW-1:0] pc,
    output logic [isaPkg::dataW-1:0] pcPlus2,
    output logic                     halted
);
    logic                     taken;           // Branch condition holds
    logic [isaPkg::dataW-1:0] pcNext;

    assign pcPlus2 = pc + isaPkg::pcStep;

    always_comb begin
        case (instr[15:11])
            isaPkg::opBeqz: taken = (rsVal == '0);
            isaPkg::opBnez: taken = (rsVal != '0);
            isaPkg::opBltz: taken = rsVal[isaPkg::dataW-1];
            isaPkg::opBgez: taken = !rsVal[isaPkg::dataW-1];
            default:        taken = 1'b0;
        endcase
        if (regJmp) pcNext = rsVal + imm;
        else if (pcSel || (branch && taken)) pcNext = pcPlus2 + imm;
        else pcNext = pcPlus2;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (halt) halted <= 1'b1;          // Sticky until reset
            if (!halt && !halted) pc <= pcNext;
        end
    end

    // Catches misaligned jump targets
    pcEven: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
        else $error("Odd pc %h", pc);
endmodule

// File: alu.sv
// ALU
`timescale 1ns/1ps
module alu (
    input  logic [isaPkg::dataW-1:0] opA,      // Rs
    input  logic [isaPkg::dataW-1:0] opB,      // Rt or immediate
    input  logic [isaPkg::opW-1:0]   aluCntrl,
    input  logic [1:0]               funct,    // R-format function bits
    output logic [isaPkg::dataW-1:0] result
);
    localparam int w = isaPkg::dataW;

    logic [w:0]     sum;                       // Carry-extended add
    logic [w-1:0]   diff;
    logic [2*w-1:0] rolW;
    logic [2*w-1:0] rorW;
    logic [w-1:0]   rev;
    logic [3:0]     shAmt;

    assign shAmt = opB[3:0];                   // Shifts use the low 4 bits
    assign sum   = {1'b0, opA} + {1'b0, opB};
    assign diff  = opB - opA;                  // SUB is Rt - Rs in this ISA
    assign rolW  = {opA, opA} << shAmt;        // Upper half holds the rotate
    assign rorW  = {opA, opA} >> shAmt;

    always_comb begin
        for (int i = 0; i < w; i++) begin
            rev[i] = opA[w-1-i];
        end
    end

    always_comb begin
        case (aluCntrl)
            isaPkg::opSubi:  result = diff;
            isaPkg::opXori:  result = opA ^ opB;
            isaPkg::opAndni: result = opA & ~opB;
            isaPkg::opRoli:  result = rolW[2*w-1:w];
            isaPkg::opSlli:  result = opA << shAmt;
            isaPkg::opRori:  result = rorW[w-1:0];
            isaPkg::opSrli:  result = opA >> shAmt;
            isaPkg::opSlbi:  result = {opA[7:0], 8'h00} | opB;
            isaPkg::opLbi:   result = opB;
            isaPkg::opBtr:   result = rev;
            isaPkg::opArith: begin
                case (funct)
                    2'b00:   result = sum[w-1:0];
                    2'b01:   result = diff;
                    2'b10:   result = opA ^ opB;
                    default: result = opA & ~opB;
                endcase
            end
            isaPkg::opShift: begin
                case (funct)
                    2'b00:   result = rolW[2*w-1:w];
                    2'b01:   result = opA << shAmt;
                    2'b10:   result = rorW[w-1:0];
                    default: result = opA >> shAmt;
                endcase
            end
            isaPkg::opSeq: result = {{(w-1){1'b0}}, opA == opB};
            isaPkg::opSlt: result = {{(w-1){1'b0}}, $signed(opA) < $signed(opB)};
            isaPkg::opSle: result = {{(w-1){1'b0}}, $signed(opA) <= $signed(opB)};
            isaPkg::opSco: result = {{(w-1){1'b0}}, sum[w]};
            default:       result = sum[w-1:0];  // ADDI and memory address
        endcase
    end
endmodule

// File: regFile.sv
// Register file
`timescale 1ns/1ps
module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [isaPkg::regAddrW-1:0] rdAddrA,
    input  logic [isaPkg::regAddrW-1:0] rdAddrB,
    output logic [isaPkg::dataW-1:0]    rdDataA,
    output logic [isaPkg::dataW-1:0]    rdDataB,
    input  logic                        we,
    input  logic [isaPkg::regAddrW-1:0] wrAddr,
    input  logic [isaPkg::dataW-1:0]    wrData
);
    logic [isaPkg::dataW-1:0] regs [0:(1 << isaPkg::regAddrW)-1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << isaPkg::regAddrW); i++) begin
                regs[i] <= '0;                 // All registers start at zero
            end
        end else if (we) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];            // Old value during a same-cycle write
    assign rdDataB = regs[rdAddrB];
endmodule

// File: immExtend.sv
// Immediate extender
`timescale 1ns/1ps
module immExtend (
    input  logic [isaPkg::dataW-1:0] instr,
    input  logic [2:0]               immSel,   // Sign flag and size code
    output logic [isaPkg::dataW-1:0] imm
);
    logic signBit;                             // Fill bit for the upper part

    always_comb begin
        case (immSel[1:0])
            2'b00: begin                       // 5-bit field
                signBit = immSel[2] & instr[4];
                imm     = {{(isaPkg::dataW-5){signBit}}, instr[4:0]};
            end
            2'b01: begin                       // 8-bit field
                signBit = immSel[2] & instr[7];
                imm     = {{(isaPkg::dataW-8){signBit}}, instr[7:0]};
            end
            default: begin                     // 11-bit displacement
                signBit = immSel[2] & instr[10];
                imm     = {{(isaPkg::dataW-11){signBit}}, instr[10:0]};
            end
        endcase
    end

    always_comb begin
        assert (immSel[1:0] != 2'b11) else $error("Unused immediate size code %b", immSel);
    end
endmodule

// File: control.sv
// Instruction decoder
`timescale 1ns/1ps
module control (
    input  logic [isaPkg::opW-1:0] instrOp,    // Top 5 bits of instr
    output logic                   regWrite,
    output logic [1:0]             destRegSel,
    output logic                   pcSel,      // Direct jump
    output logic                   regJmp,     // Jump from Rs
    output logic                   memEnable,
    output logic                   memWr,
    output logic [isaPkg::opW-1:0] aluCntrl,
    output logic                   val2Reg,    // Write back memory data
    output logic                   aluSel,     // Immediate as operand B
    output logic [2:0]             immSel,
    output logic                   halt,
    output logic [1:0]             linkSel,
    output logic                   branch      // Conditional branch
);
    always_comb begin
        regWrite   = 1'b0;                     // Nothing changes unless a group says so
        destRegSel = ctrlPkg::destSelRdI;
        pcSel      = 1'b0;
        regJmp     = 1'b0;
        memEnable  = 1'b0;
        memWr      = 1'b0;
        aluCntrl   = instrOp;                  // ALU decodes the opcode itself
        val2Reg    = 1'b0;
        aluSel     = 1'b0;
        immSel     = ctrlPkg::immSel5s;
        halt       = 1'b0;
        linkSel    = ctrlPkg::linkNone;
        branch     = 1'b0;
        case (instrOp)
            isaPkg::opHalt: halt = 1'b1;
            isaPkg::opNop, isaPkg::opSiic, isaPkg::opRti: ;  // SIIC and RTI behave as NOP
            isaPkg::opAddi, isaPkg::opSubi: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
            end
            isaPkg::opXori, isaPkg::opAndni,
            isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
                immSel   = ctrlPkg::immSel5z;  // Logic and shift immediates are unsigned
            end
            isaPkg::opSt: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;              // Address is Rs + imm
            end
            isaPkg::opLd: begin
                memEnable = 1'b1;
                regWrite  = 1'b1;
                val2Reg   = 1'b1;
                aluSel    = 1'b1;
            end
            isaPkg::opStu: begin
                memEnable  = 1'b1;
                memWr      = 1'b1;
                regWrite   = 1'b1;             // Rs gets the address
                aluSel     = 1'b1;
                destRegSel = ctrlPkg::destSelRs;
            end
            isaPkg::opBtr, isaPkg::opArith, isaPkg::opShift,
            isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco: begin
                regWrite   = 1'b1;
                destRegSel = ctrlPkg::destSelRdR;
            end
            isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
                branch = 1'b1;
                immSel = ctrlPkg::immSel8s;
            end
            isaPkg::opLbi: begin
                regWrite   = 1'b1;
                destRegSel = ctrlPkg::destSelRs;
                immSel     = ctrlPkg::immSel8s;
                linkSel    = ctrlPkg::linkLbi;
                aluSel     = 1'b1;
            end
            isaPkg::opSlbi: begin
                regWrite   = 1'b1;
                destRegSel = ctrlPkg::destSelRs;
                immSel     = ctrlPkg::immSel8z;
                aluSel     = 1'b1;             // (Rs << 8) | imm
            end
            isaPkg::opJ, isaPkg::opJal: begin
                pcSel  = 1'b1;
                immSel = ctrlPkg::immSel11s;
                if (instrOp == isaPkg::opJal) begin
                    regWrite   = 1'b1;
                    destRegSel = ctrlPkg::destSelR7;
                    linkSel    = ctrlPkg::linkPc;
                end
            end
            isaPkg::opJr, isaPkg::opJalr: begin
                regJmp = 1'b1;
                immSel = ctrlPkg::immSel8s;
                if (instrOp == isaPkg::opJalr) begin
                    regWrite   = 1'b1;
                    destRegSel = ctrlPkg::destSelR7;
                    linkSel    = ctrlPkg::linkPc;
                end
            end
            default: ;                         // All 32 opcodes are listed above
        endcase
    end

    always_comb begin
        assert (!memWr || memEnable) else $error("memWr without memEnable, op %b", instrOp);
    end
endmodule

// File: ctrlPkg.sv
// Decoder select encodings
package ctrlPkg;
    // Destination register choice
    localparam logic [1:0] destSelRs  = 2'b00;  // Rs field
    localparam logic [1:0] destSelRdR = 2'b01;  // Rd of R-format
    localparam logic [1:0] destSelR7  = 2'b10;  // Link register
    localparam logic [1:0] destSelRdI = 2'b11;  // Rd of I-format 1

    // Extender codes where bit 2 sign extends and bits 1:0 give the field size
    localparam logic [2:0] immSel5s  = 3'b100;
    localparam logic [2:0] immSel5z  = 3'b000;
    localparam logic [2:0] immSel8s  = 3'b101;
    localparam logic [2:0] immSel8z  = 3'b001;
    localparam logic [2:0] immSel11s = 3'b110;

    // Write-back overrides
    localparam logic [1:0] linkNone = 2'b00;    // ALU or memory result
    localparam logic [1:0] linkLbi  = 2'b01;    // Extended immediate
    localparam logic [1:0] linkPc   = 2'b10;    // Return address
endpackage

// File: isaPkg.sv
// WISC instruction set constants
package isaPkg;
    localparam int dataW    = 16;              // Word width
    localparam int opW      = 5;               // Opcode width
    localparam int regAddrW = 3;               // Register index width
    localparam logic [regAddrW-1:0] linkReg = 3'd7;  // JAL/JALR link target
    localparam logic [dataW-1:0] pcStep = 16'd2;     // Bytes per instruction

    // Special ops
    localparam logic [opW-1:0] opHalt  = 5'b00000;
    localparam logic [opW-1:0] opNop   = 5'b00001;
    localparam logic [opW-1:0] opSiic  = 5'b00010;
    localparam logic [opW-1:0] opRti   = 5'b00011;
    // Jumps
    localparam logic [opW-1:0] opJ     = 5'b00100;
    localparam logic [opW-1:0] opJr    = 5'b00101;
    localparam logic [opW-1:0] opJal   = 5'b00110;
    localparam logic [opW-1:0] opJalr  = 5'b00111;
    // Immediate ALU ops share their low two bits with the R-format funct
    localparam logic [opW-1:0] opAddi  = 5'b01000;
    localparam logic [opW-1:0] opSubi  = 5'b01001;
    localparam logic [opW-1:0] opXori  = 5'b01010;
    localparam logic [opW-1:0] opAndni = 5'b01011;
    localparam logic [opW-1:0] opBeqz  = 5'b01100;
    localparam logic [opW-1:0] opBnez  = 5'b01101;
    localparam logic [opW-1:0] opBltz  = 5'b01110;
    localparam logic [opW-1:0] opBgez  = 5'b01111;
    localparam logic [opW-1:0] opSt    = 5'b10000;
    localparam logic [opW-1:0] opLd    = 5'b10001;
    localparam logic [opW-1:0] opSlbi  = 5'b10010;
    localparam logic [opW-1:0] opStu   = 5'b10011;
    localparam logic [opW-1:0] opRoli  = 5'b10100;
    localparam logic [opW-1:0] opSlli  = 5'b10101;
    localparam logic [opW-1:0] opRori  = 5'b10110;
    localparam logic [opW-1:0] opSrli  = 5'b10111;
    localparam logic [opW-1:0] opLbi   = 5'b11000;
    localparam logic [opW-1:0] opBtr   = 5'b11001;
    localparam logic [opW-1:0] opShift = 5'b11010;  // ROL/SLL/ROR/SRL by funct
    localparam logic [opW-1:0] opArith = 5'b11011;  // ADD/SUB/XOR/ANDN by funct
    localparam logic [opW-1:0] opSeq   = 5'b11100;
    localparam logic [opW-1:0] opSlt   = 5'b11101;
    localparam logic [opW-1:0] opSle   = 5'b11110;
    localparam logic [opW-1:0] opSco   = 5'b11111;
endpackage
